/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the NTT core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sources.f \
    --top-module ntt_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vntt_tb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "Testbench executable exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

/* sources.f */
src/ntt_pkg.sv
src/ntt_bf_if.sv
src/ntt_mod_mult.sv
src/ntt_butterfly.sv
src/ntt_butterfly_2x2.sv
src/ntt_core_top.sv
verification/ntt_tb.sv

/* src/ntt_bf_if.sv */
// Operand and result bundle of one butterfly unit
// Operands are driven by the 2x2 network, results by the unit
// No valid or handshake travels with the data

`timescale 1ns/100ps
`default_nettype none

interface ntt_bf_if #(
    parameter int COEF_WIDTH = ntt_pkg::COEF_W
);

    // Operands u, v and twiddle or accumulator w
    logic [COEF_WIDTH-1:0] opu;
    logic [COEF_WIDTH-1:0] opv;
    logic [COEF_WIDTH-1:0] opw;

    // Butterfly pair and pointwise lane result
    logic [COEF_WIDTH-1:0] res_u;
    logic [COEF_WIDTH-1:0] res_v;
    logic [COEF_WIDTH-1:0] res_pw;

    // Network side
    modport source (output opu, opv, opw, input res_u, res_v, res_pw);

    // Butterfly side
    modport unit (input opu, opv, opw, output res_u, res_v, res_pw);

endinterface

`default_nettype wire

/* src/ntt_butterfly.sv */
// One butterfly unit for ct, gs and the pointwise modes
// Every mode takes four cycles from operands to results, fully pipelined
// Mode and accumulate must hold steady while data is in flight
// Operands are assumed below q, results are fully reduced

`timescale 1ns/100ps
`default_nettype none

module ntt_butterfly #(
    parameter int COEF_WIDTH = ntt_pkg::COEF_W
) (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize_i,
    input  ntt_pkg::mode_e mode_i,
    input  logic           accumulate_i,
    ntt_bf_if.unit         bf
);

    localparam int DLY = ntt_pkg::MUL_LATENCY;

    // Stage 1 sum, difference and delayed twiddle
    logic [COEF_WIDTH-1:0] s1_sum;
    logic [COEF_WIDTH-1:0] s1_diff;
    logic [COEF_WIDTH-1:0] w_d1;
    // Stage-1 result waiting for the multiplier
    logic [DLY-1:0][COEF_WIDTH-1:0] s_dly;
    logic [COEF_WIDTH-1:0]          s_in;
    // Addend of the final stage, u for ct and w for pwm
    logic [DLY-1:0][COEF_WIDTH-1:0] x_dly;
    logic [COEF_WIDTH-1:0]          x_in;
    // Multiplier operands and product
    logic [COEF_WIDTH-1:0] mul_a;
    logic [COEF_WIDTH-1:0] mul_b;
    logic [COEF_WIDTH-1:0] prod;
    // Final add/subtract stage
    logic [COEF_WIDTH-1:0] fin_sum;
    logic [COEF_WIDTH-1:0] fin_diff;

    function automatic logic [COEF_WIDTH-1:0] add_mod(input logic [COEF_WIDTH-1:0] a,
                                                      input logic [COEF_WIDTH-1:0] b);
        logic [COEF_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= (COEF_WIDTH+1)'(ntt_pkg::NTT_Q)) begin
            s = s - (COEF_WIDTH+1)'(ntt_pkg::NTT_Q);
        end
        return s[COEF_WIDTH-1:0];
    endfunction

    function automatic logic [COEF_WIDTH-1:0] sub_mod(input logic [COEF_WIDTH-1:0] a,
                                                      input logic [COEF_WIDTH-1:0] b);
        logic [COEF_WIDTH:0] d;
        d = {1'b0, a} - {1'b0, b};
        // Borrow out means a < b, wrap back into range
        if (d[COEF_WIDTH]) begin
            d = d + (COEF_WIDTH+1)'(ntt_pkg::NTT_Q);
        end
        return d[COEF_WIDTH-1:0];
    endfunction

    // ----------------------------------------------------------
    // Mode steering
    // ----------------------------------------------------------
    // gs multiplies the stage-1 difference, ct takes v*w, pwm takes u*v
    assign mul_a = (mode_i == ntt_pkg::gs) ? s1_diff :
                   (mode_i == ntt_pkg::ct) ? bf.opv : bf.opu;
    assign mul_b = (mode_i == ntt_pkg::gs) ? w_d1 :
                   (mode_i == ntt_pkg::ct) ? bf.opw : bf.opv;

    // pws carries the difference, gs and pwa the sum
    assign s_in = (mode_i == ntt_pkg::pws) ? s1_diff : s1_sum;

    // Running sum only joins when accumulating
    assign x_in = (mode_i == ntt_pkg::ct) ? bf.opu :
                  accumulate_i ? bf.opw : '0;

    ntt_mod_mult #(
        .COEF_WIDTH(COEF_WIDTH)
    ) i_mod_mult (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .a_i      (mul_a),
        .b_i      (mul_b),
        .p_o      (prod)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_sum   <= '0;
            s1_diff  <= '0;
            w_d1     <= '0;
            s_dly    <= '0;
            x_dly    <= '0;
            fin_sum  <= '0;
            fin_diff <= '0;
        end else if (zeroize_i) begin
            s1_sum   <= '0;
            s1_diff  <= '0;
            w_d1     <= '0;
            s_dly    <= '0;
            x_dly    <= '0;
            fin_sum  <= '0;
            fin_diff <= '0;
        end else begin
            s1_sum   <= add_mod(bf.opu, bf.opv);
            s1_diff  <= sub_mod(bf.opu, bf.opv);
            w_d1     <= bf.opw;
            s_dly    <= {s_dly[DLY-2:0], s_in};
            x_dly    <= {x_dly[DLY-2:0], x_in};
            // u+wv and u-wv for ct, uv+w for pwm
            fin_sum  <= add_mod(x_dly[DLY-1], prod);
            fin_diff <= sub_mod(x_dly[DLY-1], prod);
        end
    end

    // ----------------------------------------------------------
    // Results, all four cycles after the operands
    // ----------------------------------------------------------
    assign bf.res_u  = (mode_i == ntt_pkg::gs) ? s_dly[DLY-1] : fin_sum;
    // gs product comes straight from the multiplier register
    assign bf.res_v  = (mode_i == ntt_pkg::gs) ? prod : fin_diff;
    assign bf.res_pw = (mode_i == ntt_pkg::pwm) ? fin_sum : s_dly[DLY-1];

endmodule

`default_nettype wire

/* src/ntt_butterfly_2x2.sv */
// Two-stage 2x2 butterfly network with four pointwise lanes
// ct/gs results appear 8 cycles after enable_i, pointwise after 4
// Mode and accumulate must hold for a whole batch, drain between modes
// No back-pressure, results must be taken on the ready_o cycle

`timescale 1ns/100ps
`default_nettype none

module ntt_butterfly_2x2 #(
    parameter int COEF_WIDTH = ntt_pkg::COEF_W
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       zeroize_i,
    input  logic                       enable_i,
    input  logic                       accumulate_i,
    input  ntt_pkg::mode_e             mode_i,
    input  logic [COEF_WIDTH-1:0]      u00_i,
    input  logic [COEF_WIDTH-1:0]      u01_i,
    input  logic [COEF_WIDTH-1:0]      v00_i,
    input  logic [COEF_WIDTH-1:0]      v01_i,
    input  logic [COEF_WIDTH-1:0]      w00_i,
    input  logic [COEF_WIDTH-1:0]      w01_i,
    input  logic [COEF_WIDTH-1:0]      w10_i,
    input  logic [COEF_WIDTH-1:0]      w11_i,
    input  logic [3:0][COEF_WIDTH-1:0] pw_u_i,
    input  logic [3:0][COEF_WIDTH-1:0] pw_v_i,
    input  logic [3:0][COEF_WIDTH-1:0] pw_w_i,
    output logic [COEF_WIDTH-1:0]      u20_o,
    output logic [COEF_WIDTH-1:0]      v20_o,
    output logic [COEF_WIDTH-1:0]      u21_o,
    output logic [COEF_WIDTH-1:0]      v21_o,
    output logic [3:0][COEF_WIDTH-1:0] pw_res_o,
    output logic                       ready_o
);

    localparam int BF_LAT  = ntt_pkg::BF_LATENCY;
    localparam int NET_LAT = ntt_pkg::NET_LATENCY;

    logic pwo_mode;
    // Stage-2 twiddles wait for the stage-1 results
    logic [BF_LAT-1:0][COEF_WIDTH-1:0] w10_dly;
    logic [BF_LAT-1:0][COEF_WIDTH-1:0] w11_dly;
    // Enable delayed by up to the network latency
    logic [NET_LAT-1:0] ready_sr;
    // Network operands per unit, 0/1 stage 1 and 2/3 stage 2
    logic [3:0][COEF_WIDTH-1:0] net_u;
    logic [3:0][COEF_WIDTH-1:0] net_v;
    logic [3:0][COEF_WIDTH-1:0] net_w;

    ntt_bf_if #(.COEF_WIDTH(COEF_WIDTH)) bf_if [4] ();

    assign pwo_mode = mode_i inside {ntt_pkg::pwm, ntt_pkg::pwa, ntt_pkg::pws};

    // ----------------------------------------------------------
    // Butterfly wiring for ct and gs
    // ----------------------------------------------------------
    always_comb begin
        net_u[0] = u00_i;
        net_v[0] = v00_i;
        net_w[0] = w00_i;
        net_u[1] = u01_i;
        net_v[1] = v01_i;
        net_w[1] = w01_i;
        // u10 and u11 from unit 0, v10 and v11 from unit 1
        net_u[2] = bf_if[0].res_u;
        net_v[2] = bf_if[1].res_u;
        net_w[2] = w10_dly[BF_LAT-1];
        net_u[3] = bf_if[0].res_v;
        net_v[3] = bf_if[1].res_v;
        net_w[3] = w11_dly[BF_LAT-1];
    end

    // Pointwise lanes bypass the network and feed each unit directly
    for (genvar i = 0; i < 4; i++) begin : g_unit
        assign bf_if[i].opu = pwo_mode ? pw_u_i[i] : net_u[i];
        assign bf_if[i].opv = pwo_mode ? pw_v_i[i] : net_v[i];
        assign bf_if[i].opw = pwo_mode ? pw_w_i[i] : net_w[i];
        assign pw_res_o[i]  = bf_if[i].res_pw;

        ntt_butterfly #(
            .COEF_WIDTH(COEF_WIDTH)
        ) i_bf (
            .clk         (clk),
            .reset_n     (reset_n),
            .zeroize_i   (zeroize_i),
            .mode_i      (mode_i),
            .accumulate_i(accumulate_i),
            .bf          (bf_if[i])
        );
    end

    assign u20_o = bf_if[2].res_u;
    assign v20_o = bf_if[2].res_v;
    assign u21_o = bf_if[3].res_u;
    assign v21_o = bf_if[3].res_v;

    // ----------------------------------------------------------
    // Twiddle delay line and ready strobe
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly  <= '0;
            w11_dly  <= '0;
            ready_sr <= '0;
        end else if (zeroize_i) begin
            // Flushed sets never raise ready
            w10_dly  <= '0;
            w11_dly  <= '0;
            ready_sr <= '0;
        end else begin
            w10_dly  <= {w10_dly[BF_LAT-2:0], w10_i};
            w11_dly  <= {w11_dly[BF_LAT-2:0], w11_i};
            ready_sr <= {ready_sr[NET_LAT-2:0], enable_i};
        end
    end

    // Tap picked by mode, one stage or the full network
    assign ready_o = pwo_mode ? ready_sr[BF_LAT-1] : ready_sr[NET_LAT-1];

endmodule

`default_nettype wire

/* src/ntt_core_top.sv */
// Top level of the unmasked NTT arithmetic core
// Plain ports only, pointwise lanes flattened to single coefficients
// enable_i is a one-cycle strobe, ready_o the matching delayed strobe

`timescale 1ns/100ps
`default_nettype none

module ntt_core_top #(
    parameter int COEF_WIDTH = ntt_pkg::COEF_W
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  enable_i,
    input  logic                  accumulate_i,
    input  ntt_pkg::mode_e        mode_i,
    input  logic [COEF_WIDTH-1:0] u00_i,
    input  logic [COEF_WIDTH-1:0] u01_i,
    input  logic [COEF_WIDTH-1:0] v00_i,
    input  logic [COEF_WIDTH-1:0] v01_i,
    input  logic [COEF_WIDTH-1:0] w00_i,
    input  logic [COEF_WIDTH-1:0] w01_i,
    input  logic [COEF_WIDTH-1:0] w10_i,
    input  logic [COEF_WIDTH-1:0] w11_i,
    input  logic [COEF_WIDTH-1:0] pw_u0_i,
    input  logic [COEF_WIDTH-1:0] pw_u1_i,
    input  logic [COEF_WIDTH-1:0] pw_u2_i,
    input  logic [COEF_WIDTH-1:0] pw_u3_i,
    input  logic [COEF_WIDTH-1:0] pw_v0_i,
    input  logic [COEF_WIDTH-1:0] pw_v1_i,
    input  logic [COEF_WIDTH-1:0] pw_v2_i,
    input  logic [COEF_WIDTH-1:0] pw_v3_i,
    input  logic [COEF_WIDTH-1:0] pw_w0_i,
    input  logic [COEF_WIDTH-1:0] pw_w1_i,
    input  logic [COEF_WIDTH-1:0] pw_w2_i,
    input  logic [COEF_WIDTH-1:0] pw_w3_i,
    output logic [COEF_WIDTH-1:0] u20_o,
    output logic [COEF_WIDTH-1:0] v20_o,
    output logic [COEF_WIDTH-1:0] u21_o,
    output logic [COEF_WIDTH-1:0] v21_o,
    output logic [COEF_WIDTH-1:0] pw_res0_o,
    output logic [COEF_WIDTH-1:0] pw_res1_o,
    output logic [COEF_WIDTH-1:0] pw_res2_o,
    output logic [COEF_WIDTH-1:0] pw_res3_o,
    output logic                  ready_o
);

    // Lane 0 sits in the low slice
    logic [3:0][COEF_WIDTH-1:0] pw_u;
    logic [3:0][COEF_WIDTH-1:0] pw_v;
    logic [3:0][COEF_WIDTH-1:0] pw_w;
    logic [3:0][COEF_WIDTH-1:0] pw_res;

    assign pw_u = {pw_u3_i, pw_u2_i, pw_u1_i, pw_u0_i};
    assign pw_v = {pw_v3_i, pw_v2_i, pw_v1_i, pw_v0_i};
    assign pw_w = {pw_w3_i, pw_w2_i, pw_w1_i, pw_w0_i};

    assign pw_res0_o = pw_res[0];
    assign pw_res1_o = pw_res[1];
    assign pw_res2_o = pw_res[2];
    assign pw_res3_o = pw_res[3];

    ntt_butterfly_2x2 #(
        .COEF_WIDTH(COEF_WIDTH)
    ) i_butterfly_2x2 (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .enable_i    (enable_i),
        .accumulate_i(accumulate_i),
        .mode_i      (mode_i),
        .u00_i       (u00_i),
        .u01_i       (u01_i),
        .v00_i       (v00_i),
        .v01_i       (v01_i),
        .w00_i       (w00_i),
        .w01_i       (w01_i),
        .w10_i       (w10_i),
        .w11_i       (w11_i),
        .pw_u_i      (pw_u),
        .pw_v_i      (pw_v),
        .pw_w_i      (pw_w),
        .u20_o       (u20_o),
        .v20_o       (v20_o),
        .u21_o       (u21_o),
        .v21_o       (v21_o),
        .pw_res_o    (pw_res),
        .ready_o     (ready_o)
    );

endmodule

`default_nettype wire

/* src/ntt_mod_mult.sv */
// Pipelined modular multiplier, three cycles from a_i/b_i to p_o
// Reduction relies on 2^23 = 2^13 - 1 mod q, so COEF_WIDTH must be 23
// Inputs must be below q, the output is fully reduced
// Zeroize clears every pipeline register

`timescale 1ns/100ps
`default_nettype none

module ntt_mod_mult #(
    parameter int COEF_WIDTH = ntt_pkg::COEF_W
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic [COEF_WIDTH-1:0] a_i,
    input  logic [COEF_WIDTH-1:0] b_i,
    output logic [COEF_WIDTH-1:0] p_o
);

    localparam int PROD_W = 2 * COEF_WIDTH;
    // Shift of the 2^13 term in the folding identity
    localparam int FOLD_K = 13;
    // One fold of a full product stays below 2^37
    localparam int FOLD_W = COEF_WIDTH + FOLD_K + 1;

    logic [PROD_W-1:0]     prod_q;
    logic [FOLD_W-1:0]     fold1_q;
    logic [FOLD_W-1:0]     fold2;
    logic [FOLD_W-1:0]     fold3;
    logic [COEF_WIDTH-1:0] p_d;
    logic [COEF_WIDTH-1:0] p_q;

    // Replace hi*2^23 by hi*(2^13 - 1), keeping the low 23 bits
    function automatic logic [FOLD_W-1:0] fold(input logic [PROD_W-1:0] x);
        logic [PROD_W-1:0] hi;
        logic [PROD_W-1:0] lo;
        hi = x >> COEF_WIDTH;
        lo = PROD_W'(x[COEF_WIDTH-1:0]);
        return FOLD_W'((hi << FOLD_K) - hi + lo);
    endfunction

    // ----------------------------------------------------------
    // Stage 3 reduction
    // ----------------------------------------------------------
    always_comb begin
        // Second fold leaves under 2^28
        fold2 = fold(PROD_W'(fold1_q));
        // Small final fold brings the value under 2q
        fold3 = fold(PROD_W'(fold2));
        // One conditional subtraction of q
        if (fold3 >= FOLD_W'(ntt_pkg::NTT_Q)) begin
            p_d = COEF_WIDTH'(fold3 - FOLD_W'(ntt_pkg::NTT_Q));
        end else begin
            p_d = COEF_WIDTH'(fold3);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q  <= '0;
            fold1_q <= '0;
            p_q     <= '0;
        end else if (zeroize_i) begin
            prod_q  <= '0;
            fold1_q <= '0;
            p_q     <= '0;
        end else begin
            // Stage 1 full 46-bit product
            prod_q  <= PROD_W'(a_i) * PROD_W'(b_i);
            // Stage 2 first fold of the high half
            fold1_q <= fold(prod_q);
            p_q     <= p_d;
        end
    end

    assign p_o = p_q;

endmodule

`default_nettype wire

/* src/ntt_pkg.sv */
// Shared constants and opcodes for the NTT arithmetic core
// Arithmetic is modulo the 23-bit prime q = 2^23 - 2^13 + 1
// Latencies are fixed and must match the RTL pipelines
// Inputs to every unit are assumed already reduced below q

`default_nettype none

package ntt_pkg;

    // ----------------------------------------------------------
    // Modulus and coefficient size
    // ----------------------------------------------------------
    localparam int unsigned NTT_Q = 32'd8380417;

    // Default coefficient width, passed down from the top level
    localparam int COEF_W = 23;

    // ----------------------------------------------------------
    // Pipeline latencies in clock cycles
    // ----------------------------------------------------------
    // Modular multiplier, product plus two reduction stages
    localparam int MUL_LATENCY = 3;

    // One butterfly, identical for every mode
    localparam int BF_LATENCY = 4;

    // Two butterfly stages back to back, used by ct and gs
    localparam int NET_LATENCY = 2 * BF_LATENCY;

    // ----------------------------------------------------------
    // Operation modes
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        ct  = 3'd0,  // Forward Cooley-Tukey butterflies
        gs  = 3'd1,  // Inverse Gentleman-Sande butterflies
        pwm = 3'd2,  // Pointwise multiply, optional accumulate
        pwa = 3'd3,  // Pointwise add
        pws = 3'd4   // Pointwise subtract
    } mode_e;

endpackage

`default_nettype wire

/* verification/ntt_tb.sv */
// Testbench for the NTT arithmetic core, table of sets applied batch by batch
// Expected values come from modular golden functions, q = 8380417
// Inputs change 2 ns after the rising edge and outputs are sampled on the falling edge
// Sets sharing a name form one back-to-back batch, the pipeline drains between batches

`timescale 1ns/100ps
`default_nettype none

module ntt_tb;

    localparam int W = 23;
    localparam longint Q = 64'd8380417;
    localparam logic [W-1:0] QM1 = 23'd8380416;
    localparam int MAX_ROWS = 64;
    localparam int DRAIN = 4;
    localparam int TIMEOUT = MAX_ROWS * (8 + DRAIN) + 200;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic enable;
    logic accumulate;
    ntt_pkg::mode_e mode;
    logic [3:0][W-1:0] in_u;
    logic [3:0][W-1:0] in_v;
    logic [3:0][W-1:0] in_w;
    logic [W-1:0] u20, v20, u21, v21;
    logic [W-1:0] pw_res0, pw_res1, pw_res2, pw_res3;
    logic ready;

    // Stimulus and expected table, one row per input set
    string             tbl_name [MAX_ROWS];
    ntt_pkg::mode_e    tbl_mode [MAX_ROWS];
    logic              tbl_acc  [MAX_ROWS];
    logic [3:0][W-1:0] tbl_u    [MAX_ROWS];
    logic [3:0][W-1:0] tbl_v    [MAX_ROWS];
    logic [3:0][W-1:0] tbl_w    [MAX_ROWS];
    logic [3:0][W-1:0] tbl_exp  [MAX_ROWS];
    int n_rows = 0;

    // Row index and due ready cycle of each set in flight
    int exp_rows[$];
    int exp_cycles[$];
    int cycle = 0;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [31:0] lfsr_state;
    int mon_row;
    int mon_cyc;
    logic [3:0][W-1:0] mon_act;

    ntt_core_top #(.COEF_WIDTH(W)) i_ntt_core_top (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize), .enable_i(enable),
        .accumulate_i(accumulate), .mode_i(mode),
        .u00_i(in_u[0]), .u01_i(in_u[1]), .v00_i(in_v[0]), .v01_i(in_v[1]),
        .w00_i(in_w[0]), .w01_i(in_w[1]), .w10_i(in_w[2]), .w11_i(in_w[3]),
        .pw_u0_i(in_u[0]), .pw_u1_i(in_u[1]), .pw_u2_i(in_u[2]), .pw_u3_i(in_u[3]),
        .pw_v0_i(in_v[0]), .pw_v1_i(in_v[1]), .pw_v2_i(in_v[2]), .pw_v3_i(in_v[3]),
        .pw_w0_i(in_w[0]), .pw_w1_i(in_w[1]), .pw_w2_i(in_w[2]), .pw_w3_i(in_w[3]),
        .u20_o(u20), .v20_o(v20), .u21_o(u21), .v21_o(v21),
        .pw_res0_o(pw_res0), .pw_res1_o(pw_res1), .pw_res2_o(pw_res2),
        .pw_res3_o(pw_res3), .ready_o(ready)
    );

    // ----------------------------------------------------------
    // Golden modular arithmetic
    // ----------------------------------------------------------
    function automatic logic [W-1:0] addq(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) + longint'(b)) % Q);
    endfunction

    function automatic logic [W-1:0] subq(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) - longint'(b) + Q) % Q);
    endfunction

    function automatic logic [W-1:0] mulq(input logic [W-1:0] a, input logic [W-1:0] b);
        return W'((longint'(a) * longint'(b)) % Q);
    endfunction

    // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One bit per LFSR step and a redraw until below q
    task automatic rand_coef(output logic [W-1:0] c);
        logic [W-1:0] x;
        x = '1;
        while (x >= W'(Q)) begin
            for (int b = 0; b < W; b++) begin
                lfsr_state = lfsr_next(lfsr_state);
                x = {x[W-2:0], lfsr_state[0]};
            end
        end
        c = x;
    endtask

    // Append one set with its expected outputs
    task automatic add_row(input string name, input ntt_pkg::mode_e m, input logic acc,
                           input logic [3:0][W-1:0] u, input logic [3:0][W-1:0] v,
                           input logic [3:0][W-1:0] w);
        logic [W-1:0] u10, u11, v10, v11, t0, t1;
        logic [3:0][W-1:0] e;
        case (m)
            ntt_pkg::ct: begin
                t0 = mulq(v[0], w[0]);
                t1 = mulq(v[1], w[1]);
                u10 = addq(u[0], t0);
                u11 = subq(u[0], t0);
                v10 = addq(u[1], t1);
                v11 = subq(u[1], t1);
                t0 = mulq(v10, w[2]);
                t1 = mulq(v11, w[3]);
                e = {subq(u11, t1), addq(u11, t1), subq(u10, t0), addq(u10, t0)};
            end
            ntt_pkg::gs: begin
                u10 = addq(u[0], v[0]);
                u11 = mulq(subq(u[0], v[0]), w[0]);
                v10 = addq(u[1], v[1]);
                v11 = mulq(subq(u[1], v[1]), w[1]);
                e = {mulq(subq(u11, v11), w[3]), addq(u11, v11),
                     mulq(subq(u10, v10), w[2]), addq(u10, v10)};
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    if (m == ntt_pkg::pwm) begin
                        e[k] = addq(mulq(u[k], v[k]), acc ? w[k] : '0);
                    end else if (m == ntt_pkg::pwa) begin
                        e[k] = addq(u[k], v[k]);
                    end else begin
                        e[k] = subq(u[k], v[k]);
                    end
                end
            end
        endcase
        tbl_name[n_rows] = name;
        tbl_mode[n_rows] = m;
        tbl_acc[n_rows] = acc;
        tbl_u[n_rows] = u;
        tbl_v[n_rows] = v;
        tbl_w[n_rows] = w;
        tbl_exp[n_rows] = e;
        n_rows++;
    endtask

    task automatic add_rand(input string name, input ntt_pkg::mode_e m, input logic acc,
                            input int count);
        logic [3:0][W-1:0] u, v, w;
        for (int n = 0; n < count; n++) begin
            for (int k = 0; k < 4; k++) begin
                rand_coef(u[k]);
                rand_coef(v[k]);
                rand_coef(w[k]);
            end
            add_row(name, m, acc, u, v, w);
        end
    endtask

    // All zero, all q-1, then u zero against q-1 operands
    task automatic add_edges(input string name, input ntt_pkg::mode_e m, input logic acc);
        add_row(name, m, acc, '0, '0, '0);
        add_row(name, m, acc, {4{QM1}}, {4{QM1}}, {4{QM1}});
        add_row(name, m, acc, '0, {4{QM1}}, {4{QM1}});
    endtask

    task automatic drive_row(input int r);
        mode = tbl_mode[r];
        accumulate = tbl_acc[r];
        in_u = tbl_u[r];
        in_v = tbl_v[r];
        in_w = tbl_w[r];
    endtask

    // Outputs all zero and no ready strobe
    task automatic check_idle(input string name);
        logic [7:0][W-1:0] outs;
        outs = {pw_res3, pw_res2, pw_res1, pw_res0, v21, u21, v20, u20};
        for (int k = 0; k < 8; k++) begin
            if (outs[k] !== '0) begin
                $display("error %s output %0d: expected 000000 actual %h",
                         name, k, outs[k]);
                errors++;
            end
        end
        if (ready !== 1'b0) begin
            $display("error %s ready_o: expected 0 actual %b", name, ready);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("test %-8s ok", name);
            tests_passed++;
        end else begin
            $display("test %-8s FAILED with %0d errors", name, errors - mark);
            tests_failed++;
        end
    endtask

    // ----------------------------------------------------------
    // Clock, cycle count and timeout
    // ----------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    end

    // Each ready pops the oldest set in flight and checks it
    always @(negedge clk) begin
        if (reset_n && ready) begin
            if (exp_rows.size() == 0) begin
                $display("ready_o pulsed in cycle %0d with no set in flight", cycle);
                errors++;
            end else begin
                mon_row = exp_rows.pop_front();
                mon_cyc = exp_cycles.pop_front();
                if (tbl_mode[mon_row] inside {ntt_pkg::ct, ntt_pkg::gs}) begin
                    mon_act = {v21, u21, v20, u20};
                end else begin
                    mon_act = {pw_res3, pw_res2, pw_res1, pw_res0};
                end
                if (cycle != mon_cyc) begin
                    $display("error %s row %0d ready cycle: expected %0d actual %0d",
                             tbl_name[mon_row], mon_row, mon_cyc, cycle);
                    errors++;
                end
                for (int k = 0; k < 4; k++) begin
                    if (mon_act[k] !== tbl_exp[mon_row][k]) begin
                        $display("error %s row %0d out %0d: expected %h actual %h",
                                 tbl_name[mon_row], mon_row, k, tbl_exp[mon_row][k],
                                 mon_act[k]);
                        errors++;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int i;
        int first;
        int mark;
        reset_n = 1'b0;
        zeroize = 1'b0;
        enable = 1'b0;
        accumulate = 1'b0;
        mode = ntt_pkg::ct;
        in_u = '0;
        in_v = '0;
        in_w = '0;
        lfsr_state = 32'd89761;

        add_rand("ct_rand", ntt_pkg::ct, 1'b0, 6);
        add_edges("ct_edge", ntt_pkg::ct, 1'b0);
        add_rand("gs_rand", ntt_pkg::gs, 1'b0, 6);
        add_edges("gs_edge", ntt_pkg::gs, 1'b0);
        add_rand("pwm", ntt_pkg::pwm, 1'b0, 6);
        add_rand("pwm_acc", ntt_pkg::pwm, 1'b1, 6);
        add_edges("pwm_acc", ntt_pkg::pwm, 1'b1);
        add_rand("pwa", ntt_pkg::pwa, 1'b0, 5);
        add_edges("pwa", ntt_pkg::pwa, 1'b0);
        add_rand("pws", ntt_pkg::pws, 1'b0, 5);
        add_edges("pws", ntt_pkg::pws, 1'b0);

        repeat (5) @(posedge clk);
        #2 reset_n = 1'b1;
        @(negedge clk);
        mark = errors;
        check_idle("reset");
        report_test("reset", mark);

        // Each batch back to back, then wait for every ready
        i = 0;
        while (i < n_rows) begin
            first = i;
            mark = errors;
            while (i < n_rows && tbl_name[i] == tbl_name[first]) begin
                @(posedge clk);
                #2;
                drive_row(i);
                enable = 1'b1;
                exp_rows.push_back(i);
                exp_cycles.push_back(cycle +
                    ((tbl_mode[i] inside {ntt_pkg::ct, ntt_pkg::gs}) ? 8 : 4));
                i++;
            end
            @(posedge clk);
            #2 enable = 1'b0;
            while (exp_rows.size() != 0) begin
                @(posedge clk);
            end
            repeat (DRAIN) @(posedge clk);
            report_test(tbl_name[first], mark);
        end

        // Zeroize with three ct sets in flight, none may come out
        mark = errors;
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            #2;
            drive_row(n);
            enable = 1'b1;
        end
        @(posedge clk);
        #2;
        enable = 1'b0;
        zeroize = 1'b1;
        in_u = '0;
        in_v = '0;
        in_w = '0;
        // Pipeline clears on the next edge
        @(posedge clk);
        #2 zeroize = 1'b0;
        @(negedge clk);
        check_idle("zeroize");
        repeat (12) @(negedge clk);
        check_idle("zeroize");
        report_test("zeroize", mark);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
